// File: core_pkg.sv
package core_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    localparam inst_t NOP_INST  = 32'h0000_0013;
    localparam addr_t PC_STEP   = 32'd4;
    localparam int    REG_COUNT = 32;

    // opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {BR_NONE, BR_BEQ, BR_BNE, BR_JAL} br_kind_e;

    typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

    typedef enum logic {OP2_RS2, OP2_IMM} op2_sel_e;

    typedef struct packed {
        alu_op_e   alu_op;
        op2_sel_e  op2_sel;
        br_kind_e  br_kind;
        logic      mem_read;
        logic      mem_write;
        wb_sel_e   wb_sel;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      use_rs1;
        logic      use_rs2;
    } ctrl_t;

    // one forwarding source, ready means data is final in that stage
    typedef struct packed {
        logic      valid;
        logic      ready;
        reg_addr_t rd;
        xlen_t     data;
    } fwd_t;

    typedef struct packed {
        logic  valid;
        logic  wen;
        addr_t addr;
        xlen_t wdata;
    } dreq_t;

    typedef struct packed {
        logic  valid;
        xlen_t rdata;
    } dresp_t;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        reg_addr_t rd;
        xlen_t     data;
    } retire_t;

endpackage

// File: inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import core_pkg::*; (
    input  inst_t inst_i,
    output ctrl_t ctrl_o,
    output xlen_t imm_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i_fmt;
    xlen_t      imm_s_fmt;
    xlen_t      imm_b_fmt;
    xlen_t      imm_u_fmt;
    xlen_t      imm_j_fmt;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign imm_i_fmt = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s_fmt = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b_fmt = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                        inst_i[11:8], 1'b0};
    assign imm_u_fmt = {inst_i[31:12], 12'b0};
    assign imm_j_fmt = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                        inst_i[30:21], 1'b0};

    always_comb begin
        ctrl_t c;
        c = '0;
        c.alu_op  = ALU_ADD;
        c.op2_sel = OP2_IMM;
        c.br_kind = BR_NONE;
        c.wb_sel  = WB_NONE;
        imm_o     = '0;
        unique case (opcode)
            OPC_OP: begin
                c.op2_sel = OP2_RS2;
                c.use_rs1 = 1'b1;
                c.use_rs2 = 1'b1;
                c.wb_sel  = WB_ALU;
                case ({funct7, funct3})
                    10'b0000000_000: c.alu_op = ALU_ADD;
                    10'b0100000_000: c.alu_op = ALU_SUB;
                    10'b0000000_111: c.alu_op = ALU_AND;
                    10'b0000000_110: c.alu_op = ALU_OR;
                    10'b0000000_100: c.alu_op = ALU_XOR;
                    10'b0000000_010: c.alu_op = ALU_SLT;
                    default: begin
                        c.use_rs1 = 1'b0;
                        c.use_rs2 = 1'b0;
                        c.wb_sel  = WB_NONE;
                    end
                endcase
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b000) begin
                    c.use_rs1 = 1'b1;
                    c.wb_sel  = WB_ALU;
                    imm_o     = imm_i_fmt;
                end
            end
            OPC_LUI: begin
                c.alu_op = ALU_PASS_B;
                c.wb_sel = WB_ALU;
                imm_o    = imm_u_fmt;
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin
                    c.use_rs1  = 1'b1;
                    c.mem_read = 1'b1;
                    c.wb_sel   = WB_MEM;
                    imm_o      = imm_i_fmt;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    c.use_rs1   = 1'b1;
                    c.use_rs2   = 1'b1;
                    c.mem_write = 1'b1;
                    imm_o       = imm_s_fmt;
                end
            end
            OPC_BRANCH: begin
                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                    c.op2_sel = OP2_RS2;
                    c.use_rs1 = 1'b1;
                    c.use_rs2 = 1'b1;
                    c.br_kind = (funct3 == 3'b000) ? BR_BEQ : BR_BNE;
                    imm_o     = imm_b_fmt;
                end
            end
            OPC_JAL: begin
                c.br_kind = BR_JAL;
                c.wb_sel  = WB_PC4;
                imm_o     = imm_j_fmt;
            end
            default: ;
        endcase
        c.rs1 = c.use_rs1 ? inst_i[19:15] : '0;
        c.rs2 = c.use_rs2 ? inst_i[24:20] : '0;
        // x0 destination never writes back
        c.rd  = inst_i[11:7];
        if (c.rd == '0) begin
            c.wb_sel = WB_NONE;
        end
        if (c.wb_sel == WB_NONE) begin
            c.rd = '0;
        end
        ctrl_o = c;
    end

endmodule

// File: register_file.sv
`timescale 1ns/1ps

module register_file import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    output xlen_t     rs1_data_o,
    output xlen_t     rs2_data_o,
    input  logic      wen_i,
    input  reg_addr_t rd_i,
    input  xlen_t     wdata_i
);

    xlen_t regs_q [REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wen_i && rd_i != '0) begin
            regs_q[rd_i] <= wdata_i;
        end
    end

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

    // decode maps every x0 destination to no writeback
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        wen_i |-> rd_i != '0);

endmodule

// File: operand_select.sv
`timescale 1ns/1ps

module operand_select import core_pkg::*; (
    input  ctrl_t ctrl_i,
    input  addr_t pc_i,
    input  xlen_t imm_i,
    input  xlen_t rs1_data_i,
    input  xlen_t rs2_data_i,
    input  fwd_t  fw_exe_i,
    input  fwd_t  fw_mem_i,
    input  fwd_t  fw_wb_i,
    output xlen_t op1_o,
    output xlen_t op2_o,
    output xlen_t rs2_val_o,
    output logic  hazard_o
);

    xlen_t rs1_val;
    xlen_t rs2_val;

    function automatic logic slot_hit(fwd_t slot, reg_addr_t rs);
        return slot.valid && slot.rd == rs && rs != '0;
    endfunction

    // youngest stage first
    function automatic xlen_t pick(reg_addr_t rs, xlen_t rf_data, fwd_t exe,
                                   fwd_t mem, fwd_t wb);
        if (slot_hit(exe, rs)) begin
            return exe.data;
        end else if (slot_hit(mem, rs)) begin
            return mem.data;
        end else if (slot_hit(wb, rs)) begin
            return wb.data;
        end
        return rf_data;
    endfunction

    assign rs1_val = pick(ctrl_i.rs1, rs1_data_i, fw_exe_i, fw_mem_i, fw_wb_i);
    assign rs2_val = pick(ctrl_i.rs2, rs2_data_i, fw_exe_i, fw_mem_i, fw_wb_i);

    // load still in execute, value not there yet
    assign hazard_o = !fw_exe_i.ready &&
                      ((ctrl_i.use_rs1 && slot_hit(fw_exe_i, ctrl_i.rs1)) ||
                       (ctrl_i.use_rs2 && slot_hit(fw_exe_i, ctrl_i.rs2)));

    assign op1_o     = ctrl_i.use_rs1 ? rs1_val : pc_i;
    assign op2_o     = (ctrl_i.op2_sel == OP2_IMM) ? imm_i : rs2_val;
    assign rs2_val_o = rs2_val;

endmodule

// File: alu_branch.sv
`timescale 1ns/1ps

module alu_branch import core_pkg::*; (
    input  ctrl_t ctrl_i,
    input  addr_t pc_i,
    input  xlen_t imm_i,
    input  xlen_t op1_i,
    input  xlen_t op2_i,
    input  xlen_t rs2_val_i,
    output xlen_t result_o,
    output logic  taken_o,
    output addr_t next_pc_o
);

    addr_t target;
    logic  equal;

    always_comb begin
        unique case (ctrl_i.alu_op)
            ALU_ADD:    result_o = op1_i + op2_i;
            ALU_SUB:    result_o = op1_i - op2_i;
            ALU_AND:    result_o = op1_i & op2_i;
            ALU_OR:     result_o = op1_i | op2_i;
            ALU_XOR:    result_o = op1_i ^ op2_i;
            ALU_SLT:    result_o = xlen_t'($signed(op1_i) < $signed(op2_i));
            ALU_PASS_B: result_o = op2_i;
            default:    result_o = '0;
        endcase
    end

    // branch and jal targets are both pc relative
    assign target = pc_i + imm_i;
    assign equal  = (op1_i == rs2_val_i);

    always_comb begin
        unique case (ctrl_i.br_kind)
            BR_BEQ:  taken_o = equal;
            BR_BNE:  taken_o = !equal;
            BR_JAL:  taken_o = 1'b1;
            default: taken_o = 1'b0;
        endcase
    end

    assign next_pc_o = taken_o ? target : pc_i + PC_STEP;

endmodule

// File: load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit import core_pkg::*; (
    input  logic   clk,
    input  logic   rst_n_i,
    input  logic   valid_i,
    input  ctrl_t  ctrl_i,
    input  xlen_t  addr_i,
    input  xlen_t  wdata_i,
    output dreq_t  dreq_o,
    input  dresp_t dresp_i,
    output xlen_t  rdata_o,
    output logic   stall_o
);

    typedef enum logic {IDLE, WAIT} lsu_state_e;

    lsu_state_e state_q;
    xlen_t      rdata_q;
    logic       access;

    // the memory stage holds its fields while the access is open
    assign access       = valid_i && (ctrl_i.mem_read || ctrl_i.mem_write);
    assign dreq_o.valid = access;
    assign dreq_o.wen   = ctrl_i.mem_write;
    assign dreq_o.addr  = addr_i;
    assign dreq_o.wdata = wdata_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: if (access) state_q <= WAIT;
                WAIT: if (dresp_i.valid) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dresp_i.valid) begin
            rdata_q <= dresp_i.rdata;
        end
    end

    assign stall_o = access && !(state_q == WAIT && dresp_i.valid);
    assign rdata_o = dresp_i.valid ? dresp_i.rdata : rdata_q;

    a_resp_in_wait: assert property (@(posedge clk) disable iff (!rst_n_i)
        dresp_i.valid |-> state_q == WAIT);

endmodule

// File: pipeline_core.sv
`timescale 1ns/1ps

module pipeline_core import core_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    fetch_valid_i,
    input  addr_t   fetch_pc_i,
    input  inst_t   fetch_inst_i,
    output logic    fetch_ready_o,
    output logic    redirect_valid_o,
    output addr_t   redirect_pc_o,
    output dreq_t   dreq_o,
    input  dresp_t  dresp_i,
    output retire_t retire_o
);

    logic  id_valid, ds_valid, exe_valid, mem_valid, wb_valid;
    addr_t id_pc, ds_pc, exe_pc, mem_pc, wb_pc;
    inst_t id_inst;
    ctrl_t id_ctrl, ds_ctrl, exe_ctrl, mem_ctrl;
    xlen_t id_imm, ds_imm, exe_imm;
    xlen_t exe_op1, exe_op2, exe_rs2;
    xlen_t mem_result, mem_rs2;
    logic  wb_wen;
    reg_addr_t wb_rd;
    xlen_t wb_data;
    logic  exe_is_new, exe_checked;
    logic  redirect_q;
    addr_t redirect_pc_q;

    xlen_t rs1_data, rs2_data, ds_op1, ds_op2, ds_rs2;
    logic  ds_hazard_raw, ds_hazard;
    xlen_t exe_result, exe_fwd_data, mem_rdata, mem_fwd_data;
    logic  lsu_stall;
    addr_t exe_next_pc;
    fwd_t  fw_exe, fw_mem, fw_wb;

    ////////////////////
    // stall and flush

    // instruction in exe must be compared against a younger one
    logic branch_fail, exe_branch_stall;
    logic mem_stall, exe_stall, ds_stall, id_stall;

    assign branch_fail = exe_valid && (exe_is_new || !exe_checked) &&
                         (ds_valid ? ds_pc != exe_next_pc :
                          id_valid ? id_pc != exe_next_pc : 1'b0);
    assign exe_branch_stall = exe_valid &&
                              ((!ds_valid && !id_valid && (exe_is_new || !exe_checked)) ||
                               branch_fail);

    assign mem_stall = lsu_stall;
    assign exe_stall = mem_stall || exe_branch_stall;
    assign ds_hazard = ds_valid && ds_hazard_raw;
    assign ds_stall  = ds_hazard || (ds_valid && exe_stall);
    assign id_stall  = id_valid && ds_stall;

    assign fetch_ready_o    = !id_stall;
    assign redirect_valid_o = redirect_q;
    assign redirect_pc_o    = redirect_pc_q;

    ////////////////////
    // pipeline registers

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_valid    <= 1'b0;
            ds_valid    <= 1'b0;
            exe_valid   <= 1'b0;
            mem_valid   <= 1'b0;
            wb_valid    <= 1'b0;
            exe_is_new  <= 1'b0;
            exe_checked <= 1'b0;
            redirect_q  <= 1'b0;
        end else begin
            redirect_q <= branch_fail;
            if (branch_fail) begin
                exe_checked <= 1'b1;
            end

            if (branch_fail || redirect_q) begin
                id_valid <= 1'b0;
            end else if (!id_stall) begin
                id_valid <= fetch_valid_i;
                if (fetch_valid_i) begin
                    exe_checked <= 1'b0;
                end
            end

            if (branch_fail) begin
                ds_valid <= 1'b0;
            end else if (!ds_stall) begin
                ds_valid <= id_valid;
            end

            if (exe_stall) begin
                exe_is_new <= 1'b0;
            end else begin
                exe_valid  <= ds_valid && !ds_hazard;
                exe_is_new <= 1'b1;
            end

            if (!mem_stall) begin
                mem_valid <= exe_valid && !exe_branch_stall;
            end

            wb_valid <= mem_valid && !mem_stall;
        end
    end

    // payload follows the same enables
    always_ff @(posedge clk) begin
        redirect_pc_q <= exe_next_pc;
        if (!id_stall) begin
            id_pc   <= fetch_pc_i;
            id_inst <= fetch_valid_i ? fetch_inst_i : NOP_INST;
        end
        if (!ds_stall) begin
            ds_pc   <= id_pc;
            ds_ctrl <= id_ctrl;
            ds_imm  <= id_imm;
        end
        if (!exe_stall) begin
            exe_pc   <= ds_pc;
            exe_ctrl <= ds_ctrl;
            exe_imm  <= ds_imm;
            exe_op1  <= ds_op1;
            exe_op2  <= ds_op2;
            exe_rs2  <= ds_rs2;
        end
        if (!mem_stall) begin
            mem_pc     <= exe_pc;
            mem_ctrl   <= exe_ctrl;
            mem_result <= exe_fwd_data;
            mem_rs2    <= exe_rs2;
        end
        wb_pc   <= mem_pc;
        wb_wen  <= mem_ctrl.wb_sel != WB_NONE;
        wb_rd   <= mem_ctrl.rd;
        wb_data <= mem_fwd_data;
    end

    ////////////////////
    // forwarding slots

    assign exe_fwd_data = (exe_ctrl.wb_sel == WB_PC4) ? exe_pc + PC_STEP : exe_result;
    assign mem_fwd_data = (mem_ctrl.wb_sel == WB_MEM) ? mem_rdata : mem_result;

    assign fw_exe = '{valid: exe_valid && exe_ctrl.wb_sel != WB_NONE,
                      ready: exe_ctrl.wb_sel != WB_MEM,
                      rd: exe_ctrl.rd, data: exe_fwd_data};
    assign fw_mem = '{valid: mem_valid && mem_ctrl.wb_sel != WB_NONE,
                      ready: 1'b1, rd: mem_ctrl.rd, data: mem_fwd_data};
    assign fw_wb  = '{valid: wb_valid && wb_wen, ready: 1'b1, rd: wb_rd, data: wb_data};

    assign retire_o = '{valid: wb_valid && wb_wen, pc: wb_pc, rd: wb_rd, data: wb_data};

    inst_decoder u_decoder (
        .inst_i (id_inst),
        .ctrl_o (id_ctrl),
        .imm_o  (id_imm)
    );

    register_file u_regfile (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_i      (ds_ctrl.rs1),
        .rs2_i      (ds_ctrl.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wen_i      (wb_valid && wb_wen),
        .rd_i       (wb_rd),
        .wdata_i    (wb_data)
    );

    operand_select u_opsel (
        .ctrl_i     (ds_ctrl),
        .pc_i       (ds_pc),
        .imm_i      (ds_imm),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .fw_exe_i   (fw_exe),
        .fw_mem_i   (fw_mem),
        .fw_wb_i    (fw_wb),
        .op1_o      (ds_op1),
        .op2_o      (ds_op2),
        .rs2_val_o  (ds_rs2),
        .hazard_o   (ds_hazard_raw)
    );

    alu_branch u_alu (
        .ctrl_i    (exe_ctrl),
        .pc_i      (exe_pc),
        .imm_i     (exe_imm),
        .op1_i     (exe_op1),
        .op2_i     (exe_op2),
        .rs2_val_i (exe_rs2),
        .result_o  (exe_result),
        .taken_o   (),
        .next_pc_o (exe_next_pc)
    );

    load_store_unit u_lsu (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (mem_valid),
        .ctrl_i  (mem_ctrl),
        .addr_i  (mem_result),
        .wdata_i (mem_rs2),
        .dreq_o  (dreq_o),
        .dresp_i (dresp_i),
        .rdata_o (mem_rdata),
        .stall_o (lsu_stall)
    );

    a_dreq_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        dreq_o.valid && !dresp_i.valid |=> dreq_o.valid && $stable(dreq_o));

    a_redirect_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_valid_o |=> !redirect_valid_o);

endmodule

// File: tb_core.sv
`timescale 1ns/1ps

module tb_core import core_pkg::*; ();

    localparam int NUM_TESTS   = 5;
    localparam int MAX_INST    = 16;
    localparam int MAX_RETIRE  = 16;
    localparam int MAX_REDIR   = 4;
    localparam int MAX_STORE   = 4;
    localparam int DRAIN       = 10;
    localparam int IDLE_CYCLES = 20;

    logic    clk;
    logic    rst_n_i       = 1'b0;
    logic    fetch_valid_i = 1'b0;
    addr_t   fetch_pc_i    = '0;
    inst_t   fetch_inst_i  = NOP_INST;
    logic    fetch_ready_o;
    logic    redirect_valid_o;
    addr_t   redirect_pc_o;
    dreq_t   dreq_o;
    dresp_t  dresp_i       = '0;
    retire_t retire_o;

    // test table, one index per row
    string     test_name   [NUM_TESTS];
    inst_t     prog        [NUM_TESTS][MAX_INST];
    int        prog_len    [NUM_TESTS];
    addr_t     start_pc    [NUM_TESTS];
    int        exp_count   [NUM_TESTS];
    addr_t     exp_pc      [NUM_TESTS][MAX_RETIRE];
    reg_addr_t exp_rd      [NUM_TESTS][MAX_RETIRE];
    xlen_t     exp_data    [NUM_TESTS][MAX_RETIRE];
    int        redir_count [NUM_TESTS];
    addr_t     exp_redir   [NUM_TESTS][MAX_REDIR];
    int        store_count [NUM_TESTS];
    addr_t     store_addr  [NUM_TESTS][MAX_STORE];
    xlen_t     store_data  [NUM_TESTS][MAX_STORE];

    int          cur_test = 0;
    logic        fetch_on = 1'b0;
    addr_t       fetch_pc;
    xlen_t       mem [256];
    logic [31:0] lfsr_q   = 32'h09ea_80c6;
    logic        mem_busy = 1'b0;
    int          mem_wait;
    xlen_t       mem_rdata;

    addr_t     ret_pc_q   [$];
    reg_addr_t ret_rd_q   [$];
    xlen_t     ret_data_q [$];
    addr_t     redir_q    [$];
    int        dreq_cycles     = 0;
    int        checks          = 0;
    int        errors          = 0;
    int        watchdog_cycles = 0;

    pipeline_core dut_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_pc_i       (fetch_pc_i),
        .fetch_inst_i     (fetch_inst_i),
        .fetch_ready_o    (fetch_ready_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o),
        .dreq_o           (dreq_o),
        .dresp_i          (dresp_i),
        .retire_o         (retire_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////
    // instruction encoders

    function automatic inst_t r_type(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                     reg_addr_t rs1, reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic inst_t addi(reg_addr_t rd, reg_addr_t rs1, xlen_t imm);
        return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic inst_t lui(reg_addr_t rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic inst_t lw(reg_addr_t rd, reg_addr_t rs1, xlen_t imm);
        return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic inst_t sw(reg_addr_t rs2, reg_addr_t rs1, xlen_t imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic inst_t branch(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
                                     xlen_t off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic inst_t jal(reg_addr_t rd, xlen_t off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    ////////////////////
    // table setup

    task automatic add_inst(int t, inst_t inst);
        prog[t][prog_len[t]] = inst;
        prog_len[t]++;
    endtask

    // instruction that must retire with rd and value
    task automatic add_step(int t, inst_t inst, reg_addr_t rd, xlen_t data);
        exp_pc[t][exp_count[t]]   = start_pc[t] + addr_t'(prog_len[t] * 4);
        add_inst(t, inst);
        exp_rd[t][exp_count[t]]   = rd;
        exp_data[t][exp_count[t]] = data;
        exp_count[t]++;
    endtask

    task automatic expect_redirect(int t, addr_t pc);
        exp_redir[t][redir_count[t]] = pc;
        redir_count[t]++;
    endtask

    // memory word that must hold data at the end of the test
    task automatic expect_store(int t, addr_t addr, xlen_t data);
        store_addr[t][store_count[t]] = addr;
        store_data[t][store_count[t]] = data;
        store_count[t]++;
    endtask

    task automatic build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            prog_len[t]    = 0;
            exp_count[t]   = 0;
            redir_count[t] = 0;
            store_count[t] = 0;
        end
        test_name[0] = "idle_after_reset";
        start_pc[0]  = 32'h0000_0000;

        test_name[1] = "alu_forward";
        start_pc[1]  = 32'h0000_0000;
        add_step(1, addi(1, 0, 32'd5), 1, 32'd5);
        add_step(1, addi(2, 1, 32'd7), 2, 32'd12);
        add_step(1, r_type(7'h00, 3'h0, 3, 1, 2), 3, 32'd17);
        add_step(1, r_type(7'h20, 3'h0, 4, 3, 1), 4, 32'd12);
        add_step(1, r_type(7'h00, 3'h4, 5, 4, 3), 5, 32'd29);
        add_step(1, r_type(7'h00, 3'h2, 6, 4, 3), 6, 32'd1);
        add_step(1, lui(7, 20'h12345), 7, 32'h1234_5000);
        add_step(1, r_type(7'h00, 3'h0, 8, 7, 6), 8, 32'h1234_5001);
        add_step(1, addi(10, 0, 32'hffff_fffd), 10, 32'hffff_fffd);
        add_step(1, r_type(7'h00, 3'h2, 11, 10, 1), 11, 32'd1);
        add_step(1, r_type(7'h00, 3'h2, 14, 1, 10), 14, 32'd0);
        add_step(1, r_type(7'h00, 3'h7, 12, 5, 2), 12, 32'd12);
        add_step(1, r_type(7'h00, 3'h6, 13, 4, 6), 13, 32'd13);

        test_name[2] = "load_store";
        start_pc[2]  = 32'h0000_0100;
        add_step(2, addi(1, 0, 32'h40), 1, 32'h40);
        add_step(2, lui(2, 20'habcde), 2, 32'habcd_e000);
        add_step(2, addi(2, 2, 32'h123), 2, 32'habcd_e123);
        add_inst(2, sw(2, 1, 32'd4));
        add_step(2, lw(3, 1, 32'd4), 3, 32'habcd_e123);
        add_step(2, r_type(7'h00, 3'h0, 4, 3, 1), 4, 32'habcd_e163);
        add_inst(2, sw(4, 1, 32'd8));
        add_step(2, lw(5, 1, 32'd8), 5, 32'habcd_e163);
        add_step(2, r_type(7'h20, 3'h0, 6, 5, 3), 6, 32'h40);
        expect_store(2, 32'h44, 32'habcd_e123);
        expect_store(2, 32'h48, 32'habcd_e163);

        // beq taken to 0x214, jal to 0x220, the rest is wrong path
        test_name[3] = "branch_jump";
        start_pc[3]  = 32'h0000_0200;
        add_step(3, addi(1, 0, 32'd3), 1, 32'd3);
        add_step(3, addi(2, 0, 32'd3), 2, 32'd3);
        add_inst(3, branch(3'b000, 1, 2, 32'd12));
        add_inst(3, addi(3, 0, 32'h11));
        add_inst(3, addi(3, 0, 32'h22));
        add_step(3, jal(5, 32'd12), 5, 32'h218);
        add_inst(3, addi(6, 0, 32'h33));
        add_inst(3, addi(6, 0, 32'h44));
        add_step(3, addi(7, 5, 32'd1), 7, 32'h219);
        expect_redirect(3, 32'h214);
        expect_redirect(3, 32'h220);

        test_name[4] = "bne_not_taken";
        start_pc[4]  = 32'h0000_0300;
        add_step(4, addi(1, 0, 32'd9), 1, 32'd9);
        add_step(4, addi(2, 0, 32'd9), 2, 32'd9);
        add_inst(4, branch(3'b001, 1, 2, 32'd8));
        add_step(4, addi(3, 1, 32'd1), 3, 32'd10);
        add_step(4, addi(4, 3, 32'd2), 4, 32'd12);
    endtask

    ////////////////////
    // fetch and memory models

    function automatic inst_t inst_at(addr_t pc);
        addr_t offset;
        offset = pc - start_pc[cur_test];
        if (pc >= start_pc[cur_test] && (offset >> 2) < prog_len[cur_test]) begin
            return prog[cur_test][offset >> 2];
        end
        return NOP_INST;
    endfunction

    // past the program end the stream is nops
    always @(posedge clk) begin
        if (!fetch_on) begin
            fetch_pc = start_pc[cur_test];
            fetch_valid_i <= 1'b0;
        end else begin
            if (redirect_valid_o) begin
                fetch_pc = redirect_pc_o;
            end else if (fetch_valid_i && fetch_ready_o) begin
                fetch_pc = fetch_pc + PC_STEP;
            end
            fetch_valid_i <= 1'b1;
            fetch_pc_i    <= fetch_pc;
            fetch_inst_i  <= inst_at(fetch_pc);
        end
    end

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] draw_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return v;
    endfunction

    task automatic fill_memory();
        for (int i = 0; i < 256; i++) begin
            mem[i] = xlen_t'(i << 2) ^ 32'h5a5a_0000;
        end
    endtask

    // response 1 to 4 cycles after the request shows up
    always @(posedge clk) begin
        if (!rst_n_i) begin
            dresp_i <= '0;
            mem_busy = 1'b0;
        end else if (dresp_i.valid) begin
            dresp_i <= '0;
        end else begin
            if (!mem_busy && dreq_o.valid) begin
                mem_busy = 1'b1;
                mem_wait = draw_bits(2);
                if (dreq_o.wen) begin
                    mem[dreq_o.addr[9:2]] = dreq_o.wdata;
                    // store responses return junk
                    mem_rdata = 32'hdead_beef;
                end else begin
                    mem_rdata = mem[dreq_o.addr[9:2]];
                end
            end
            if (mem_busy) begin
                if (mem_wait == 0) begin
                    dresp_i <= '{valid: 1'b1, rdata: mem_rdata};
                    mem_busy = 1'b0;
                end else begin
                    mem_wait--;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n_i) begin
            if (retire_o.valid) begin
                ret_pc_q.push_back(retire_o.pc);
                ret_rd_q.push_back(retire_o.rd);
                ret_data_q.push_back(retire_o.data);
            end
            if (redirect_valid_o) begin
                redir_q.push_back(redirect_pc_o);
            end
            if (dreq_o.valid) begin
                dreq_cycles++;
            end
        end
    end

    ////////////////////
    // checks and sequencing

    task automatic check_value(string what, xlen_t expected, xlen_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s expected %h actual %h", what, expected, actual);
        end
    endtask

    task automatic check_results(int t);
        int    n;
        addr_t a;
        n = ret_rd_q.size();
        if (n < exp_count[t]) begin
            errors++;
            $display("[%s] only %0d of %0d expected instructions retired",
                     test_name[t], n, exp_count[t]);
        end else if (n > exp_count[t]) begin
            errors++;
            $display("[%s] %0d instructions retired that should not have",
                     test_name[t], n - exp_count[t]);
        end
        for (int i = 0; i < exp_count[t] && i < n; i++) begin
            check_value($sformatf("%s retire %0d pc", test_name[t], i),
                        exp_pc[t][i], ret_pc_q[i]);
            check_value($sformatf("%s retire %0d rd", test_name[t], i),
                        exp_rd[t][i], ret_rd_q[i]);
            check_value($sformatf("%s retire %0d data", test_name[t], i),
                        exp_data[t][i], ret_data_q[i]);
        end
        check_value($sformatf("%s redirect count", test_name[t]),
                    redir_count[t], redir_q.size());
        for (int i = 0; i < redir_count[t] && i < redir_q.size(); i++) begin
            check_value($sformatf("%s redirect %0d pc", test_name[t], i),
                        exp_redir[t][i], redir_q[i]);
        end
        for (int i = 0; i < store_count[t]; i++) begin
            a = store_addr[t][i];
            check_value($sformatf("%s memory word %h", test_name[t], a),
                        store_data[t][i], mem[a[9:2]]);
        end
        if (prog_len[t] == 0) begin
            check_value($sformatf("%s data requests", test_name[t]), 0, dreq_cycles);
            check_value($sformatf("%s fetch ready", test_name[t]), 1, fetch_ready_o);
        end
    endtask

    task automatic run_test(int t);
        int cycles;
        int errors_before;
        int checks_before;
        errors_before = errors;
        checks_before = checks;
        @(posedge clk);
        fetch_on <= 1'b0;
        rst_n_i  <= 1'b0;
        repeat (2) @(posedge clk);
        cur_test = t;
        fill_memory();
        ret_pc_q.delete();
        ret_rd_q.delete();
        ret_data_q.delete();
        redir_q.delete();
        dreq_cycles = 0;
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        if (prog_len[t] == 0) begin
            repeat (IDLE_CYCLES) @(posedge clk);
        end else begin
            fetch_on <= 1'b1;
            cycles = 0;
            while (ret_rd_q.size() < exp_count[t] && cycles < prog_len[t] * 20) begin
                @(negedge clk);
                cycles++;
            end
            repeat (DRAIN) @(posedge clk);
        end
        @(negedge clk);
        check_results(t);
        $display("[%s] %0d checks, %0d errors", test_name[t],
                 checks - checks_before, errors - errors_before);
    endtask

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish",
                 watchdog_cycles);
        $display("test failed");
        $finish;
    end

    initial begin
        int total_len;
        build_table();
        total_len = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total_len += prog_len[t];
        end
        watchdog_cycles = total_len * 20;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
core_pkg.sv
inst_decoder.sv
register_file.sv
operand_select.sv
alu_branch.sv
load_store_unit.sv
pipeline_core.sv
tb_core.sv

// File: Bender.yml
package:
  name: pipeline_core

sources:
  - core_pkg.sv
  - inst_decoder.sv
  - register_file.sv
  - operand_select.sv
  - alu_branch.sv
  - load_store_unit.sv
  - pipeline_core.sv
  - target: test
    files:
      - tb_core.sv
